// File: include/cfg_ctrl_params.svh
`ifndef CFG_CTRL_PARAMS_SVH
`define CFG_CTRL_PARAMS_SVH

// 7-bit slave address the host calls
`define CFG_I2C_ADDR      7'h3C

`define CFG_NUM_OUT_REGS  12    // host writable
`define CFG_NUM_IN_REGS   4     // status bytes from the soc side

// equal samples needed before a new line level is taken
`define CFG_FILTER_LEN    3

// board defaults loaded at reset
`define CFG_DEF_0         8'd46     // cpu pll mul
`define CFG_DEF_1         8'h22     // cpu pll div
`define CFG_DEF_2         8'd30     // soc pll mul
`define CFG_DEF_3         8'h21     // soc pll div
`define CFG_DEF_4         8'h00     // pll ctrl
`define CFG_DEF_5         8'h02     // spi div
`define CFG_DEF_6         8'h05     // debug ctrl
`define CFG_DEF_7         8'h03     // vga and i2s own the pins
`define CFG_DEF_8         8'h00
`define CFG_DEF_9         8'h00
`define CFG_DEF_10        8'h00
`define CFG_DEF_11        8'h00

`endif

// File: hw/i2c_pkg.sv
package i2c_pkg;

    typedef logic [7:0] i2c_byte_t;     // one byte on the bus

    typedef logic [3:0] i2c_bit_cnt_t;  // 0..8 within a byte

    typedef enum logic [2:0] {
        PH_IDLE,            // waiting for a start
        PH_ADDRESS,
        PH_ACK_OUT,         // slave holds sda low
        PH_POINTER,
        PH_WRITE_DATA,
        PH_READ_DATA,
        PH_ACK_IN           // host acks or nacks a read byte
    } i2c_phase_t;

endpackage

// File: hw/cfg_ctrl_pkg.sv
package cfg_ctrl_pkg;

    typedef logic [3:0] reg_addr_t;

    // register map
    localparam reg_addr_t REG_CPU_PLL_MUL = 4'd0;
    localparam reg_addr_t REG_CPU_PLL_DIV = 4'd1;
    localparam reg_addr_t REG_SOC_PLL_MUL = 4'd2;
    localparam reg_addr_t REG_SOC_PLL_DIV = 4'd3;
    localparam reg_addr_t REG_PLL_CTRL    = 4'd4;
    localparam reg_addr_t REG_SPI_DIV     = 4'd5;
    localparam reg_addr_t REG_DBG_CTRL    = 4'd6;
    localparam reg_addr_t REG_MUX_CTRL    = 4'd7;
    localparam reg_addr_t REG_CTRL_DATA   = 4'd8;   // 4 bytes, low byte first

    typedef struct packed {
        logic [7:0]  cpu_pll_mul;
        logic [7:0]  cpu_pll_div;
        logic [7:0]  soc_pll_mul;
        logic [7:0]  soc_pll_div;
        logic [7:0]  pll_ctrl;
        logic [7:0]  spi_div;
        logic [7:0]  dbg_ctrl;
        logic [7:0]  mux_ctrl;      // bit 0 vga, bit 1 i2s
        logic [31:0] ctrl_data;
    } cfg_fields_t;

endpackage

// File: hw/cfg_ctrl_ifs.sv
`timescale 1ns/100ps

interface i2c_event_if;
    logic scl_rise;     // filtered scl edges
    logic scl_fall;
    logic start;        // sda falls while scl high
    logic stop;         // sda rises while scl high
    logic sda;          // filtered sda level

    modport sampler (output scl_rise, scl_fall, start, stop, sda);
    modport engine  (input  scl_rise, scl_fall, start, stop, sda);
endinterface

interface reg_access_if;
    import i2c_pkg::*;
    import cfg_ctrl_pkg::*;

    logic       wr_en;      // one-cycle strobes
    logic       rd_en;
    reg_addr_t  addr;
    i2c_byte_t  wdata;
    i2c_byte_t  rdata;      // combinational from addr

    modport engine (
        output wr_en, rd_en, addr, wdata,
        input  rdata
    );
    modport bank (
        input  wr_en, addr, wdata,
        output rdata
    );
endinterface

// File: hw/i2c_line_sampler.sv
`timescale 1ns/100ps
`include "cfg_ctrl_params.svh"

module i2c_line_sampler (
    input  logic         clk_50m,
    input  logic         rst_n_i,
    input  logic         scl_i,
    input  logic         sda_i,
    i2c_event_if.sampler ev
);

    localparam int SCL = 0;
    localparam int SDA = 1;
    localparam int CNT_W = $clog2(`CFG_FILTER_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CFG_FILTER_LEN - 1);

    logic [1:0]       sync1_q;
    logic [1:0]       sync2_q;
    logic [1:0]       filt_q;       // accepted levels
    logic [1:0]       filt_d_q;     // last cycle's accepted levels
    logic [CNT_W-1:0] cnt_q [2];

    always_ff @(posedge clk_50m or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q  <= 2'b11;      // bus idles high
            sync2_q  <= 2'b11;
            filt_q   <= 2'b11;
            filt_d_q <= 2'b11;
            cnt_q    <= '{default: '0};
        end else begin
            sync1_q  <= {sda_i, scl_i};
            sync2_q  <= sync1_q;
            filt_d_q <= filt_q;
            for (int i = 0; i < 2; i++) begin
                if (sync2_q[i] == filt_q[i]) begin
                    cnt_q[i] <= '0;             // glitch gone, start over
                end else if (cnt_q[i] == CNT_LAST) begin
                    filt_q[i] <= sync2_q[i];
                    cnt_q[i]  <= '0;
                end else begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign ev.scl_rise = filt_q[SCL] & ~filt_d_q[SCL];
    assign ev.scl_fall = ~filt_q[SCL] & filt_d_q[SCL];

    // scl must be steady high around the sda edge
    assign ev.start = filt_q[SCL] & filt_d_q[SCL] & ~filt_q[SDA] & filt_d_q[SDA];
    assign ev.stop  = filt_q[SCL] & filt_d_q[SCL] & filt_q[SDA] & ~filt_d_q[SDA];
    assign ev.sda   = filt_q[SDA];

endmodule

// File: hw/i2c_byte_engine.sv
`timescale 1ns/100ps
`include "cfg_ctrl_params.svh"

module i2c_byte_engine (
    input  logic         clk_50m,
    input  logic         rst_n_i,
    i2c_event_if.engine  ev,
    reg_access_if.engine ra,
    output logic         sda_oe_o
);

    import i2c_pkg::*;
    import cfg_ctrl_pkg::*;

    i2c_phase_t   phase_q;
    i2c_phase_t   ret_phase_q;      // phase after our ack
    i2c_bit_cnt_t bit_cnt_q;
    i2c_byte_t    shift_q;
    i2c_byte_t    wdata_q;
    reg_addr_t    ptr_q;
    logic         nack_q;
    logic         sda_oe_q;
    logic         wr_en_q;
    logic         rd_en_q;
    logic         shift_in;
    logic         wr_hit;
    logic         load_rd;

    assign shift_in = ev.scl_rise &&
                      (phase_q inside {PH_ADDRESS, PH_POINTER, PH_WRITE_DATA});
    assign wr_hit   = ev.scl_rise && phase_q == PH_WRITE_DATA && bit_cnt_q == 4'd7;

    // next read byte goes out when our ack or the host ack ends
    assign load_rd = ev.scl_fall &&
                     ((phase_q == PH_ACK_OUT && ret_phase_q == PH_READ_DATA) ||
                      (phase_q == PH_ACK_IN && !nack_q));

    always_ff @(posedge clk_50m or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q     <= PH_IDLE;
            ret_phase_q <= PH_IDLE;
            bit_cnt_q   <= '0;
            ptr_q       <= '0;
            nack_q      <= 1'b0;
            sda_oe_q    <= 1'b0;
            wr_en_q     <= 1'b0;
            rd_en_q     <= 1'b0;
        end else begin
            wr_en_q <= wr_hit;
            rd_en_q <= load_rd;
            if (wr_en_q || rd_en_q) begin
                ptr_q <= ptr_q + 1'b1;      // wraps at 16
            end

            if (ev.start) begin
                phase_q   <= PH_ADDRESS;    // repeated start too
                bit_cnt_q <= '0;
            end else if (ev.stop) begin
                phase_q <= PH_IDLE;
            end else if (ev.scl_rise) begin
                if (shift_in && bit_cnt_q != 4'd8) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
                if (phase_q == PH_ACK_IN) begin
                    nack_q <= ev.sda;
                end
            end else if (ev.scl_fall) begin
                sda_oe_q <= 1'b0;           // released unless driven below
                case (phase_q)
                    PH_ADDRESS: begin
                        if (bit_cnt_q == 4'd8) begin
                            if (shift_q[7:1] == `CFG_I2C_ADDR) begin
                                sda_oe_q    <= 1'b1;
                                phase_q     <= PH_ACK_OUT;
                                ret_phase_q <= shift_q[0] ? PH_READ_DATA : PH_POINTER;
                            end else begin
                                phase_q <= PH_IDLE;     // not us, wait for start
                            end
                        end
                    end
                    PH_POINTER, PH_WRITE_DATA: begin
                        if (bit_cnt_q == 4'd8) begin
                            if (phase_q == PH_POINTER) begin
                                ptr_q <= shift_q[3:0];
                            end
                            sda_oe_q    <= 1'b1;
                            phase_q     <= PH_ACK_OUT;
                            ret_phase_q <= PH_WRITE_DATA;
                        end
                    end
                    PH_ACK_OUT: begin
                        bit_cnt_q <= '0;
                        phase_q   <= ret_phase_q;
                    end
                    PH_READ_DATA: begin
                        if (bit_cnt_q == 4'd7) begin
                            phase_q <= PH_ACK_IN;   // let the host answer
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            sda_oe_q  <= ~shift_q[6];
                        end
                    end
                    PH_ACK_IN: begin
                        bit_cnt_q <= '0;
                        phase_q   <= nack_q ? PH_IDLE : PH_READ_DATA;
                    end
                    default: ;
                endcase
                if (load_rd) begin
                    sda_oe_q <= ~ra.rdata[7];   // msb first
                end
            end
        end
    end

    always_ff @(posedge clk_50m) begin
        if (shift_in) begin
            shift_q <= {shift_q[6:0], ev.sda};
        end else if (load_rd) begin
            shift_q <= ra.rdata;
        end else if (ev.scl_fall && phase_q == PH_READ_DATA) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
        if (wr_hit) begin
            wdata_q <= {shift_q[6:0], ev.sda};
        end
    end

    assign sda_oe_o = sda_oe_q;
    assign ra.wr_en = wr_en_q;
    assign ra.rd_en = rd_en_q;
    assign ra.addr  = ptr_q;
    assign ra.wdata = wdata_q;

endmodule

// File: hw/cfg_reg_bank.sv
`timescale 1ns/100ps
`include "cfg_ctrl_params.svh"

module cfg_reg_bank (
    input  logic                          clk_50m,
    input  logic                          rst_n_i,
    reg_access_if.bank                    ra,
    input  logic [8*`CFG_NUM_IN_REGS-1:0] status_i,
    output cfg_ctrl_pkg::cfg_fields_t     fields_o
);

    import cfg_ctrl_pkg::*;

    localparam logic [7:0] DEFAULTS [`CFG_NUM_OUT_REGS] = '{
        `CFG_DEF_0, `CFG_DEF_1, `CFG_DEF_2,  `CFG_DEF_3,
        `CFG_DEF_4, `CFG_DEF_5, `CFG_DEF_6,  `CFG_DEF_7,
        `CFG_DEF_8, `CFG_DEF_9, `CFG_DEF_10, `CFG_DEF_11
    };

    logic [7:0] regs_q [`CFG_NUM_OUT_REGS];
    logic       in_rw;      // address hits the writable part

    assign in_rw = ra.addr < reg_addr_t'(`CFG_NUM_OUT_REGS);

    always_ff @(posedge clk_50m or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CFG_NUM_OUT_REGS; i++) begin
                regs_q[i] <= DEFAULTS[i];
            end
        end else if (ra.wr_en && in_rw) begin
            regs_q[ra.addr] <= ra.wdata;    // status range ignored
        end
    end

    always_comb begin
        if (in_rw) begin
            ra.rdata = regs_q[ra.addr];
        end else begin
            ra.rdata = status_i[{ra.addr[1:0], 3'b000} +: 8];   // byte 12 is lowest
        end
    end

    assign fields_o.cpu_pll_mul = regs_q[REG_CPU_PLL_MUL];
    assign fields_o.cpu_pll_div = regs_q[REG_CPU_PLL_DIV];
    assign fields_o.soc_pll_mul = regs_q[REG_SOC_PLL_MUL];
    assign fields_o.soc_pll_div = regs_q[REG_SOC_PLL_DIV];
    assign fields_o.pll_ctrl    = regs_q[REG_PLL_CTRL];
    assign fields_o.spi_div     = regs_q[REG_SPI_DIV];
    assign fields_o.dbg_ctrl    = regs_q[REG_DBG_CTRL];
    assign fields_o.mux_ctrl    = regs_q[REG_MUX_CTRL];

    assign fields_o.ctrl_data = {
        regs_q[REG_CTRL_DATA + 4'd3],
        regs_q[REG_CTRL_DATA + 4'd2],
        regs_q[REG_CTRL_DATA + 4'd1],
        regs_q[REG_CTRL_DATA]
    };

endmodule

// File: hw/pin_mux.sv
`timescale 1ns/100ps

module pin_mux (
    input  logic [7:0] mux_ctrl_i,

    input  logic [7:0] vga_lo_i,
    input  logic [7:0] gpio_o_i,
    input  logic [7:0] gpio_t_i,
    output logic [7:0] gpio_i_o,
    input  logic [7:0] pad_gpio_i,
    output logic [7:0] pad_gpio_o,
    output logic [7:0] pad_gpio_t_o,    // 1 = input

    input  logic       i2s_lrclk_i,
    input  logic       i2s_sclk_i,
    input  logic       i2s_sdata_i,
    input  logic       cdbus_tx_i,
    input  logic       cdbus_tx_t_i,
    input  logic       cdbus_tx_en_i,
    input  logic       cdbus_tx_en_t_i,
    output logic       cdbus_rx_o,
    output logic       pad_lrclk_o,
    output logic       pad_lrclk_t_o,
    output logic       pad_sclk_o,
    output logic       pad_sclk_t_o,
    input  logic       pad_sdata_i,
    output logic       pad_sdata_o,
    output logic       pad_sdata_t_o
);

    logic vga_en;
    logic i2s_en;

    assign vga_en = mux_ctrl_i[0];
    assign i2s_en = mux_ctrl_i[1];

    // vga drives all eight pads, else gpio keeps its own tristates
    assign pad_gpio_o   = vga_en ? vga_lo_i : gpio_o_i;
    assign pad_gpio_t_o = vga_en ? 8'h00    : gpio_t_i;
    assign gpio_i_o     = pad_gpio_i;

    assign pad_lrclk_o   = i2s_en ? i2s_lrclk_i : cdbus_tx_i;
    assign pad_lrclk_t_o = i2s_en ? 1'b0        : cdbus_tx_t_i;
    assign pad_sclk_o    = i2s_en ? i2s_sclk_i  : cdbus_tx_en_i;
    assign pad_sclk_t_o  = i2s_en ? 1'b0        : cdbus_tx_en_t_i;
    assign pad_sdata_o   = i2s_sdata_i;
    assign pad_sdata_t_o = ~i2s_en;     // cdbus rx listens here
    assign cdbus_rx_o    = pad_sdata_i;

endmodule

// File: hw/lain_cfg_ctrl_top.sv
`timescale 1ns/100ps
`include "cfg_ctrl_params.svh"

module lain_cfg_ctrl_top (
    input  logic                          clk_50m,
    input  logic                          rst_n_i,

    input  logic                          scl_i,
    input  logic                          sda_i,
    output logic                          sda_oe_o,     // 1 pulls sda low
    input  logic [8*`CFG_NUM_IN_REGS-1:0] status_i,

    output logic [7:0]                    cpu_pll_mul_o,
    output logic [7:0]                    cpu_pll_div_o,
    output logic [7:0]                    soc_pll_mul_o,
    output logic [7:0]                    soc_pll_div_o,
    output logic [7:0]                    pll_ctrl_o,
    output logic [7:0]                    spi_div_o,
    output logic [7:0]                    dbg_ctrl_o,
    output logic [7:0]                    mux_ctrl_o,
    output logic [31:0]                   ctrl_data_o,

    input  logic [7:0]                    vga_lo_i,
    input  logic [7:0]                    gpio_o_i,
    input  logic [7:0]                    gpio_t_i,
    output logic [7:0]                    gpio_i_o,
    input  logic [7:0]                    pad_gpio_i,
    output logic [7:0]                    pad_gpio_o,
    output logic [7:0]                    pad_gpio_t_o,

    input  logic                          i2s_lrclk_i,
    input  logic                          i2s_sclk_i,
    input  logic                          i2s_sdata_i,
    input  logic                          cdbus_tx_i,
    input  logic                          cdbus_tx_t_i,
    input  logic                          cdbus_tx_en_i,
    input  logic                          cdbus_tx_en_t_i,
    output logic                          cdbus_rx_o,
    output logic                          pad_lrclk_o,
    output logic                          pad_lrclk_t_o,
    output logic                          pad_sclk_o,
    output logic                          pad_sclk_t_o,
    input  logic                          pad_sdata_i,
    output logic                          pad_sdata_o,
    output logic                          pad_sdata_t_o
);

    import cfg_ctrl_pkg::*;

    cfg_fields_t fields;

    i2c_event_if  ev_if ();
    reg_access_if ra_if ();

    i2c_line_sampler u_sampler (
        .clk_50m  (clk_50m),
        .rst_n_i  (rst_n_i),
        .scl_i    (scl_i),
        .sda_i    (sda_i),
        .ev       (ev_if.sampler)
    );

    i2c_byte_engine u_engine (
        .clk_50m  (clk_50m),
        .rst_n_i  (rst_n_i),
        .ev       (ev_if.engine),
        .ra       (ra_if.engine),
        .sda_oe_o (sda_oe_o)
    );

    cfg_reg_bank u_bank (
        .clk_50m  (clk_50m),
        .rst_n_i  (rst_n_i),
        .ra       (ra_if.bank),
        .status_i (status_i),
        .fields_o (fields)
    );

    // remaining pad ports share names with the top
    pin_mux u_pin_mux (
        .mux_ctrl_i (fields.mux_ctrl),
        .*
    );

    assign cpu_pll_mul_o = fields.cpu_pll_mul;
    assign cpu_pll_div_o = fields.cpu_pll_div;
    assign soc_pll_mul_o = fields.soc_pll_mul;
    assign soc_pll_div_o = fields.soc_pll_div;
    assign pll_ctrl_o    = fields.pll_ctrl;
    assign spi_div_o     = fields.spi_div;
    assign dbg_ctrl_o    = fields.dbg_ctrl;
    assign mux_ctrl_o    = fields.mux_ctrl;
    assign ctrl_data_o   = fields.ctrl_data;

endmodule

// File: verif/cfg_ctrl_asserts.sv
`timescale 1ns/100ps

module cfg_ctrl_asserts (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        scl_rise_i,
    input logic        scl_fall_i,
    input logic        sda_oe_i,
    input logic        wr_en_i,
    input logic        rd_en_i,
    input logic [95:0] fields_i
);

    logic scl_hi_q;     // filtered scl level rebuilt from the edges

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scl_hi_q <= 1'b1;
        end else if (scl_rise_i) begin
            scl_hi_q <= 1'b1;
        end else if (scl_fall_i) begin
            scl_hi_q <= 1'b0;
        end
    end

    // engine only moves sda on the low phase
    sda_steady_while_scl_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (scl_hi_q && !scl_fall_i) |=> $stable(sda_oe_i))
        else $error("sda_oe changed while scl was high");

    strobes_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wr_en_i && rd_en_i))
        else $error("wr_en and rd_en pulsed together");

    fields_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !wr_en_i |=> $stable(fields_i))
        else $error("fields changed without a write strobe");

endmodule

// engine and bank signals are reached through the top level
bind lain_cfg_ctrl_top cfg_ctrl_asserts u_asserts (
    .clk_i      (clk_50m),
    .rst_n_i    (rst_n_i),
    .scl_rise_i (ev_if.scl_rise),
    .scl_fall_i (ev_if.scl_fall),
    .sda_oe_i   (sda_oe_o),
    .wr_en_i    (ra_if.wr_en),
    .rd_en_i    (ra_if.rd_en),
    .fields_i   (fields)
);

// File: verif/tb_lain_cfg_ctrl.sv
`timescale 1ns/100ps
`include "cfg_ctrl_params.svh"

module tb_lain_cfg_ctrl;

    import i2c_pkg::*;
    import cfg_ctrl_pkg::*;

    typedef logic [30:0] pad_vec_t;

    logic clk_50m = 1'b0;
    logic rst_n_i, scl_i, sda_i, sda_oe_o;
    logic scl_drv, sda_drv;             // host side of the wired-and
    logic [31:0] status_i, ctrl_data_o;
    logic [7:0] cpu_pll_mul_o, cpu_pll_div_o, soc_pll_mul_o, soc_pll_div_o;
    logic [7:0] pll_ctrl_o, spi_div_o, dbg_ctrl_o, mux_ctrl_o;
    logic [7:0] vga_lo_i, gpio_o_i, gpio_t_i, gpio_i_o, pad_gpio_i, pad_gpio_o, pad_gpio_t_o;
    logic i2s_lrclk_i, i2s_sclk_i, i2s_sdata_i, cdbus_tx_i, cdbus_tx_t_i;
    logic cdbus_tx_en_i, cdbus_tx_en_t_i, cdbus_rx_o, pad_lrclk_o, pad_lrclk_t_o;
    logic pad_sclk_o, pad_sclk_t_o, pad_sdata_i, pad_sdata_o, pad_sdata_t_o;

    integer      seed = 32'h1cfced48;
    int          pat_count = 0;
    string       lines[$];
    i2c_byte_t   model[`CFG_NUM_OUT_REGS];
    cfg_fields_t dut_fields;

    lain_cfg_ctrl_top uut (.*);

    assign scl_i = scl_drv;
    assign sda_i = sda_drv & ~sda_oe_o;
    assign dut_fields = {cpu_pll_mul_o, cpu_pll_div_o, soc_pll_mul_o, soc_pll_div_o,
                         pll_ctrl_o, spi_div_o, dbg_ctrl_o, mux_ctrl_o, ctrl_data_o};

    always #10 clk_50m = ~clk_50m;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input i2c_byte_t got, input i2c_byte_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
            abort_run("register read-back wrong");
        end
    endtask

    task automatic check_fields(input cfg_fields_t got, input cfg_fields_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: fields %h, expected %h", $time, got, exp);
            abort_run("field outputs wrong");
        end
    endtask

    task automatic check_pads(input pad_vec_t got, input pad_vec_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: pads %h, expected %h", $time, got, exp);
            abort_run("pad outputs wrong");
        end
    endtask

    task automatic wait_clks(input int n);
        repeat (n) begin
            @(posedge clk_50m);
            #2;
        end
    endtask

    function automatic cfg_fields_t expected_fields();
        return {model[0], model[1], model[2], model[3], model[4], model[5], model[6],
                model[7], model[11], model[10], model[9], model[8]};
    endfunction

    // start or repeated start from either scl level
    task automatic bus_start();
        sda_drv = 1'b1;
        wait_clks(16);
        scl_drv = 1'b1;
        wait_clks(16);
        sda_drv = 1'b0;
        wait_clks(16);
        scl_drv = 1'b0;
        wait_clks(8);
    endtask

    task automatic bus_stop();
        sda_drv = 1'b0;
        wait_clks(16);
        scl_drv = 1'b1;
        wait_clks(16);
        sda_drv = 1'b1;
        wait_clks(16);
    endtask

    // one 32-clock bit that returns the sampled line and any slave drive
    task automatic bus_bit(input logic b, output logic got, output logic oe_seen);
        sda_drv = b;
        oe_seen = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (i == 8) scl_drv = 1'b1;
            if (i == 24) scl_drv = 1'b0;
            wait_clks(1);
            oe_seen |= sda_oe_o;
            if (i == 16) got = sda_i;
        end
    endtask

    task automatic send_byte(input i2c_byte_t b, output logic acked, output logic oe_seen);
        logic got;
        for (int i = 7; i >= 0; i--) bus_bit(b[i], got, oe_seen);
        bus_bit(1'b1, got, oe_seen);
        acked = !got;
    endtask

    task automatic recv_byte(input logic ack, output i2c_byte_t b);
        logic oe;
        logic dummy;
        for (int i = 7; i >= 0; i--) bus_bit(1'b1, b[i], oe);
        bus_bit(!ack, dummy, oe);
    endtask

    task automatic send_acked(input i2c_byte_t b, input string what);
        logic acked;
        logic oe;
        send_byte(b, acked, oe);
        if (!acked) abort_run({"slave did not acknowledge the ", what});
    endtask

    task automatic i2c_write(input int ptr, input int n, input i2c_byte_t d[4]);
        int p;
        bus_start();
        send_acked({`CFG_I2C_ADDR, 1'b0}, "write address");
        send_acked(8'(ptr), "pointer byte");
        p = ptr;
        for (int i = 0; i < n; i++) begin
            send_acked(d[i], "data byte");
            if (p < `CFG_NUM_OUT_REGS) model[p] = d[i];
            p = (p + 1) % 16;
        end
        wait_clks(10);
        check_fields(dut_fields, expected_fields());    // write lands before the stop
        bus_stop();
    endtask

    task automatic i2c_read(input int ptr, input int n, input i2c_byte_t exp[4]);
        i2c_byte_t b;
        bus_start();
        send_acked({`CFG_I2C_ADDR, 1'b0}, "write address");
        send_acked(8'(ptr), "pointer byte");
        bus_start();
        send_acked({`CFG_I2C_ADDR, 1'b1}, "read address");
        for (int i = 0; i < n; i++) begin
            recv_byte(i < n - 1, b);
            check_byte(b, exp[i], $sformatf("register %0d", (ptr + i) % 16));
        end
        bus_stop();
    endtask

    task automatic probe_nack(input int addr7);
        logic acked;
        logic oe;
        bus_start();
        send_byte({7'(addr7), 1'b0}, acked, oe);
        if (oe) abort_run("slave pulled sda for a foreign address");
        bus_stop();
        check_fields(dut_fields, expected_fields());
    endtask

    task automatic run_pattern(input string line);
        string     op;
        int        v[9];
        i2c_byte_t d[4];
        void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                      op, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]));
        if (op == "W" || op == "R") begin
            void'($sscanf(line, "%s %d %d", op, v[0], v[1]));  // pointer and count in decimal
        end
        for (int i = 0; i < 4; i++) d[i] = 8'(v[i + 2]);
        case (op)
            "W": i2c_write(v[0], v[1], d);
            "R": i2c_read(v[0], v[1], d);
            "S": i2c_read(12, 4, '{status_i[7:0], status_i[15:8],
                                    status_i[23:16], status_i[31:24]});
            "N": probe_nack(v[0]);
            "P": begin
                d = '{8'(v[0]), 8'h00, 8'h00, 8'h00};
                i2c_write(7, 1, d);
                {vga_lo_i, gpio_o_i, gpio_t_i, pad_gpio_i} = {8'(v[1]), 8'(v[2]),
                                                              8'(v[3]), 8'(v[4])};
                {i2s_lrclk_i, i2s_sclk_i, i2s_sdata_i, cdbus_tx_i, cdbus_tx_t_i,
                 cdbus_tx_en_i, cdbus_tx_en_t_i, pad_sdata_i} = 8'(v[5]);
                wait_clks(1);
                check_pads({pad_gpio_o, pad_gpio_t_o, gpio_i_o, pad_lrclk_o, pad_lrclk_t_o,
                            pad_sclk_o, pad_sclk_t_o, pad_sdata_o, pad_sdata_t_o, cdbus_rx_o},
                           {8'(v[6]), 8'(v[7]), 8'(v[4]), 7'(v[8])});
            end
            default: abort_run({"unknown pattern operation ", op});
        endcase
    endtask

    initial begin
        wait (pat_count != 0);
        #(longint'(pat_count) * 40 * 9 * 32 * 20);
        abort_run("timeout, the patterns did not finish in time");
    end

    initial begin
        int    fd;
        string line;
        rst_n_i = 1'b0;
        scl_drv = 1'b1;
        sda_drv = 1'b1;
        status_i = $random(seed);
        {vga_lo_i, gpio_o_i, gpio_t_i, pad_gpio_i} = '0;
        {i2s_lrclk_i, i2s_sclk_i, i2s_sdata_i, cdbus_tx_i, cdbus_tx_t_i} = '0;
        {cdbus_tx_en_i, cdbus_tx_en_t_i, pad_sdata_i} = '0;
        model = '{`CFG_DEF_0, `CFG_DEF_1, `CFG_DEF_2, `CFG_DEF_3, `CFG_DEF_4, `CFG_DEF_5,
                  `CFG_DEF_6, `CFG_DEF_7, `CFG_DEF_8, `CFG_DEF_9, `CFG_DEF_10, `CFG_DEF_11};
        fd = $fopen("verif/cfg_ctrl_patterns.txt", "r");
        if (fd == 0) abort_run("cannot open the pattern file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") lines.push_back(line);
        end
        $fclose(fd);
        if (lines.size() == 0) abort_run("the pattern file holds no patterns");
        pat_count = lines.size();
        repeat (16) @(posedge clk_50m);
        #2 rst_n_i = 1'b1;
        wait_clks(4);
        check_fields(dut_fields, expected_fields());    // defaults out of reset
        foreach (lines[i]) run_pattern(lines[i]);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: verif/cfg_ctrl_patterns.txt
# op W/R: ptr count b0 b1 b2 b3 | S: status read | N: addr7
# op P: mux vga gpio_o gpio_t pad_gpio in_bits exp_gpio exp_gpio_t exp_misc
R 0 4 2e 22 1e 21
R 4 4 00 02 05 03
R 8 4 00 00 00 00
W 8 4 11 22 33 44
R 8 4 11 22 33 44
W 2 3 1f 20 aa 00
R 2 3 1f 20 aa 00
W 11 2 77 88 00 00
R 11 1 77 00 00 00
S
W 14 4 de ad be ef
R 0 2 be ef 00 00
S
N 3d
N 5c
P 0 5a c3 0f 96 a5 c3 0f 17
P 1 5a c3 0f 96 a5 5a 00 17
P 2 5a c3 0f 96 a5 c3 0f 45
P 3 5a c3 0f 96 a5 5a 00 45

// File: files.f
+incdir+include
hw/i2c_pkg.sv
hw/cfg_ctrl_pkg.sv
hw/cfg_ctrl_ifs.sv
hw/i2c_line_sampler.sv
hw/i2c_byte_engine.sv
hw/cfg_reg_bank.sv
hw/pin_mux.sv
hw/lain_cfg_ctrl_top.sv
verif/cfg_ctrl_asserts.sv
verif/tb_lain_cfg_ctrl.sv

// File: Makefile
SOURCES := $(wildcard hw/*.sv include/*.svh verif/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_lain_cfg_ctrl

obj_dir/Vtb_lain_cfg_ctrl: files.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_lain_cfg_ctrl \
		-f files.f -o Vtb_lain_cfg_ctrl

run: obj_dir/Vtb_lain_cfg_ctrl verif/cfg_ctrl_patterns.txt
	./obj_dir/Vtb_lain_cfg_ctrl | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
